// File: common/soc_pkg.sv
package soc_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W   = 4;

  // address map
  localparam logic [ADDR_W-1:0] SRAM_BASE   = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] SERIAL_ADDR = 32'h1000_0000;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } resp_e;

  // read address channel payload
  typedef struct packed {
    logic [ADDR_W-1:0] araddr;
    logic [ID_W-1:0]   arid;
  } axi_ar_t;

  // write address channel payload
  typedef struct packed {
    logic [ADDR_W-1:0] awaddr;
    logic [ID_W-1:0]   awid;
  } axi_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } axi_w_t;

  typedef struct packed {
    logic [ID_W-1:0] bid;
    resp_e           bresp;
  } axi_b_t;

  // single beat, so rlast is always set
  typedef struct packed {
    logic [ID_W-1:0]   rid;
    logic [DATA_W-1:0] rdata;
    resp_e             rresp;
    logic              rlast;
  } axi_r_t;

endpackage

// File: mem_axi/sram_bank.sv
`timescale 1ns/1ps

module sram_bank #(
  parameter int SRAM_WORDS = 1024,
  localparam int IDX_W     = $clog2(SRAM_WORDS)
) (
  input  logic                       clk,
  input  logic [soc_pkg::STRB_W-1:0] mem_we_i,
  input  logic [IDX_W-1:0]           mem_addr_i,
  input  logic [soc_pkg::DATA_W-1:0] mem_wdata_i,
  output logic [soc_pkg::DATA_W-1:0] mem_rdata_o
);

  logic [soc_pkg::DATA_W-1:0] mem [SRAM_WORDS];

  // byte lanes written independently
  always_ff @(posedge clk) begin
    for (int b = 0; b < soc_pkg::STRB_W; b++) begin
      if (mem_we_i[b]) begin
        mem[mem_addr_i][b*8 +: 8] <= mem_wdata_i[b*8 +: 8];
      end
    end
  end

  // registered read, one cycle after the address
  always_ff @(posedge clk) begin
    mem_rdata_o <= mem[mem_addr_i];
  end

endmodule

// File: mem_axi/axi_mem_ctrl.sv
`timescale 1ns/1ps

module axi_mem_ctrl #(
  parameter int SRAM_WORDS  = 1024,
  parameter bit THROTTLE_EN = 1'b1,
  localparam int IDX_W      = $clog2(SRAM_WORDS)
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,
  input  soc_pkg::axi_ar_t           ar_i,
  input  logic                       aw_valid_i,
  output logic                       aw_ready_o,
  input  soc_pkg::axi_aw_t           aw_i,
  input  logic                       w_valid_i,
  output logic                       w_ready_o,
  input  soc_pkg::axi_w_t            w_i,
  output logic                       r_valid_o,
  input  logic                       r_ready_i,
  output soc_pkg::axi_r_t            r_o,
  output logic                       b_valid_o,
  input  logic                       b_ready_i,
  output soc_pkg::axi_b_t            b_o,
  output logic [soc_pkg::STRB_W-1:0] mem_we_o,
  output logic [IDX_W-1:0]           mem_addr_o,
  output logic [soc_pkg::DATA_W-1:0] mem_wdata_o,
  input  logic [soc_pkg::DATA_W-1:0] mem_rdata_i,
  output logic                       tx_start_o,
  output logic [7:0]                 tx_byte_o,
  input  logic                       tx_busy_i
);

  localparam logic [soc_pkg::ADDR_W-1:0] SRAM_BYTES = soc_pkg::ADDR_W'(SRAM_WORDS * 8);
  localparam logic [19:0] LFSR_SEED = 20'h00065;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_FETCH,
    ST_RD_RESP,
    ST_WR_DATA,
    ST_WR_COMMIT,
    ST_WR_RESP
  } state_e;

  typedef enum logic [1:0] {
    TGT_SRAM,
    TGT_SERIAL,
    TGT_ERR
  } tgt_e;

  state_e state_q, state_d;
  tgt_e   tgt_q, tgt_d;
  logic [19:0] lfsr_q;
  logic        tick;
  logic        commit_ok;
  logic        ar_hs, aw_hs, w_hs;
  logic [soc_pkg::ADDR_W-1:0] addr_sel, offset;
  logic [IDX_W-1:0]           idx_q, idx_d;
  logic [soc_pkg::ID_W-1:0]   id_q;
  logic [soc_pkg::DATA_W-1:0] wdata_q;
  logic [soc_pkg::STRB_W-1:0] strb_q;

  // x^20 + x^17 + 1
  assign tick = THROTTLE_EN ? lfsr_q[19] : 1'b1;

  // reads win in idle
  assign ar_ready_o = (state_q == ST_IDLE) && tick;
  assign aw_ready_o = (state_q == ST_IDLE) && tick && !ar_valid_i;
  assign w_ready_o  = (state_q == ST_WR_DATA) && tick && w_valid_i;
  assign r_valid_o  = (state_q == ST_RD_RESP);
  assign b_valid_o  = (state_q == ST_WR_RESP);

  assign ar_hs = ar_valid_i && ar_ready_o;
  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;

  // decode once, at address acceptance
  assign addr_sel = ar_valid_i ? ar_i.araddr : aw_i.awaddr;
  assign offset   = addr_sel - soc_pkg::SRAM_BASE;
  assign idx_d    = offset[IDX_W+2:3];

  always_comb begin
    if (offset < SRAM_BYTES) begin
      tgt_d = TGT_SRAM;
    end else if (addr_sel == soc_pkg::SERIAL_ADDR) begin
      tgt_d = TGT_SERIAL;
    end else begin
      tgt_d = TGT_ERR;
    end
  end

  // serial commit holds off while the transmitter is busy
  assign commit_ok = tick && !(tgt_q == TGT_SERIAL && tx_busy_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (ar_hs) begin
          state_d = ST_RD_FETCH;
        end else if (aw_hs) begin
          state_d = ST_WR_DATA;
        end
      end
      ST_RD_FETCH: begin
        if (tick) begin
          state_d = ST_RD_RESP;
        end
      end
      ST_RD_RESP: begin
        if (r_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_WR_DATA: begin
        if (w_hs) begin
          state_d = ST_WR_COMMIT;
        end
      end
      ST_WR_COMMIT: begin
        if (commit_ok) begin
          state_d = ST_WR_RESP;
        end
      end
      ST_WR_RESP: begin
        if (b_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      lfsr_q  <= LFSR_SEED;
    end else begin
      state_q <= state_d;
      lfsr_q  <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[16]};
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs || aw_hs) begin
      id_q  <= ar_hs ? ar_i.arid : aw_i.awid;
      tgt_q <= tgt_d;
      idx_q <= idx_d;
    end
    if (w_hs) begin
      wdata_q <= w_i.wdata;
      strb_q  <= w_i.wstrb;
    end
  end

  // error writes fall through with no enables
  assign mem_addr_o  = idx_q;
  assign mem_wdata_o = wdata_q;
  assign mem_we_o    = (state_q == ST_WR_COMMIT && commit_ok && tgt_q == TGT_SRAM) ?
                       strb_q : '0;
  assign tx_start_o  = (state_q == ST_WR_COMMIT) && commit_ok && (tgt_q == TGT_SERIAL);
  assign tx_byte_o   = wdata_q[7:0];

  always_comb begin
    r_o.rid   = id_q;
    r_o.rdata = (tgt_q == TGT_SRAM) ? mem_rdata_i : '0;
    r_o.rresp = (tgt_q == TGT_ERR) ? soc_pkg::RESP_DECERR : soc_pkg::RESP_OKAY;
    r_o.rlast = 1'b1;
    b_o.bid   = id_q;
    b_o.bresp = (tgt_q == TGT_ERR) ? soc_pkg::RESP_DECERR : soc_pkg::RESP_OKAY;
  end

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 4
) (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       tx_start_i,
  input  logic [7:0] tx_byte_i,
  output logic       tx_busy_o,
  output logic       uart_txd_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  logic [9:0]       shift_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [3:0]       bit_cnt_q;
  logic             busy_q;
  logic             bit_end;

  assign bit_end = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (!busy_q) begin
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      if (tx_start_i) begin
        busy_q <= 1'b1;
      end
    end else if (bit_end) begin
      clk_cnt_q <= '0;
      bit_cnt_q <= bit_cnt_q + 4'd1;
      // stop bit done
      if (bit_cnt_q == 4'd9) begin
        busy_q <= 1'b0;
      end
    end else begin
      clk_cnt_q <= clk_cnt_q + CNT_W'(1);
    end
  end

  // stop, data lsb first, start
  always_ff @(posedge clk) begin
    if (!busy_q && tx_start_i) begin
      shift_q <= {1'b1, tx_byte_i, 1'b0};
    end else if (busy_q && bit_end) begin
      shift_q <= {1'b1, shift_q[9:1]};
    end
  end

  assign tx_busy_o  = busy_q;
  assign uart_txd_o = busy_q ? shift_q[0] : 1'b1;

endmodule

// File: hdl/soc_top.sv
`timescale 1ns/1ps

module soc_top #(
  parameter int SRAM_WORDS   = 1024,
  parameter int CLKS_PER_BIT = 4,
  parameter bit THROTTLE_EN  = 1'b1
) (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             ar_valid_i,
  output logic             ar_ready_o,
  input  soc_pkg::axi_ar_t ar_i,
  input  logic             aw_valid_i,
  output logic             aw_ready_o,
  input  soc_pkg::axi_aw_t aw_i,
  input  logic             w_valid_i,
  output logic             w_ready_o,
  input  soc_pkg::axi_w_t  w_i,
  output logic             b_valid_o,
  input  logic             b_ready_i,
  output soc_pkg::axi_b_t  b_o,
  output logic             r_valid_o,
  input  logic             r_ready_i,
  output soc_pkg::axi_r_t  r_o,
  output logic             uart_txd_o
);

  localparam int IDX_W = $clog2(SRAM_WORDS);

  logic [soc_pkg::STRB_W-1:0] mem_we;
  logic [IDX_W-1:0]           mem_addr;
  logic [soc_pkg::DATA_W-1:0] mem_wdata;
  logic [soc_pkg::DATA_W-1:0] mem_rdata;
  logic                       tx_start;
  logic [7:0]                 tx_byte;
  logic                       tx_busy;

  axi_mem_ctrl #(
    .SRAM_WORDS  (SRAM_WORDS),
    .THROTTLE_EN (THROTTLE_EN)
  ) axi_mem_ctrl_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .ar_valid_i  (ar_valid_i),
    .ar_ready_o  (ar_ready_o),
    .ar_i        (ar_i),
    .aw_valid_i  (aw_valid_i),
    .aw_ready_o  (aw_ready_o),
    .aw_i        (aw_i),
    .w_valid_i   (w_valid_i),
    .w_ready_o   (w_ready_o),
    .w_i         (w_i),
    .r_valid_o   (r_valid_o),
    .r_ready_i   (r_ready_i),
    .r_o         (r_o),
    .b_valid_o   (b_valid_o),
    .b_ready_i   (b_ready_i),
    .b_o         (b_o),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata),
    .tx_start_o  (tx_start),
    .tx_byte_o   (tx_byte),
    .tx_busy_i   (tx_busy)
  );

  sram_bank #(
    .SRAM_WORDS (SRAM_WORDS)
  ) sram_bank_inst (
    .clk         (clk),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_rdata_o (mem_rdata)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) uart_tx_inst (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .tx_start_i (tx_start),
    .tx_byte_i  (tx_byte),
    .tx_busy_o  (tx_busy),
    .uart_txd_o (uart_txd_o)
  );

endmodule

// File: sim/soc_properties.sv
`timescale 1ns/1ps

module soc_properties (
  input logic                       clk,
  input logic                       rst_n_i,
  input logic                       ar_ready_o,
  input logic                       aw_ready_o,
  input logic                       w_ready_o,
  input logic                       r_valid_o,
  input logic                       r_ready_i,
  input soc_pkg::axi_r_t            r_o,
  input logic                       b_valid_o,
  input logic                       b_ready_i,
  input soc_pkg::axi_b_t            b_o,
  input logic                       tx_start_o,
  input logic [soc_pkg::STRB_W-1:0] mem_we_o
);

  // response held while the master stalls
  r_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
    else $error("read response dropped or changed before rready");

  b_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o))
    else $error("write response dropped or changed before bready");

  // nothing new accepted with a response pending
  no_accept: assert property (@(posedge clk) disable iff (!rst_n_i)
    (r_valid_o || b_valid_o) |-> !ar_ready_o && !aw_ready_o)
    else $error("address accepted while a response is pending");

  reset_quiet: assert property (@(posedge clk)
    !rst_n_i |=> !ar_ready_o && !aw_ready_o && !r_valid_o && !b_valid_o &&
                 !w_ready_o && !tx_start_o && mem_we_o == '0)
    else $error("controller outputs active right after reset");

endmodule

bind axi_mem_ctrl soc_properties soc_properties_inst (
  .clk        (clk),
  .rst_n_i    (rst_n_i),
  .ar_ready_o (ar_ready_o),
  .aw_ready_o (aw_ready_o),
  .w_ready_o  (w_ready_o),
  .r_valid_o  (r_valid_o),
  .r_ready_i  (r_ready_i),
  .r_o        (r_o),
  .b_valid_o  (b_valid_o),
  .b_ready_i  (b_ready_i),
  .b_o        (b_o),
  .tx_start_o (tx_start_o),
  .mem_we_o   (mem_we_o)
);

// File: sim/tb_soc.sv
`timescale 1ns/1ps

module tb_soc;

  localparam int SRAM_WORDS   = 1024;
  localparam int CLKS_PER_BIT = 4;
  localparam int CLK_NS       = 8;
  localparam int BIT_NS       = CLKS_PER_BIT * CLK_NS;
  localparam soc_pkg::resp_e OK = soc_pkg::RESP_OKAY;
  localparam soc_pkg::resp_e DE = soc_pkg::RESP_DECERR;

  typedef enum logic [1:0] {
    OP_RD,
    OP_WR,
    OP_RDWR
  } op_e;

  typedef struct packed {
    op_e            op;
    logic [31:0]    addr;
    logic [63:0]    wdata;
    logic [7:0]     wstrb;
    logic [3:0]     id;
    logic [63:0]    exp_rdata;
    soc_pkg::resp_e exp_resp;
  } entry_t;

  logic             clk;
  logic             rst_n_i;
  logic             ar_valid_i;
  logic             ar_ready_o;
  soc_pkg::axi_ar_t ar_i;
  logic             aw_valid_i;
  logic             aw_ready_o;
  soc_pkg::axi_aw_t aw_i;
  logic             w_valid_i;
  logic             w_ready_o;
  soc_pkg::axi_w_t  w_i;
  logic             b_valid_o;
  logic             b_ready_i;
  soc_pkg::axi_b_t  b_o;
  logic             r_valid_o;
  logic             r_ready_i;
  soc_pkg::axi_r_t  r_o;
  logic             uart_txd_o;

  entry_t           tbl [$];
  logic [63:0]      sb [int];
  logic [7:0]       exp_bytes [$];
  logic [7:0]       rx_bytes [$];
  soc_pkg::axi_r_t  r_cap;
  soc_pkg::axi_b_t  b_cap;
  integer           seed = 32'h0dba62bc;
  int               cycle = 0;
  int               limit = 0;
  int               errors = 0;
  int               ar_cnt = 0;
  int               aw_cnt = 0;
  int               w_cnt = 0;
  int               r_cnt = 0;
  int               b_cnt = 0;
  int               r_cyc = 0;
  int               b_cyc = 0;

  soc_top #(
    .SRAM_WORDS   (SRAM_WORDS),
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .THROTTLE_EN  (1'b1)
  ) soc_top_inst (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .ar_i       (ar_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .aw_i       (aw_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .w_i        (w_i),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .b_o        (b_o),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_o        (r_o),
    .uart_txd_o (uart_txd_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // handshake counters and captured responses
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (ar_valid_i && ar_ready_o) ar_cnt <= ar_cnt + 1;
    if (aw_valid_i && aw_ready_o) aw_cnt <= aw_cnt + 1;
    if (w_valid_i && w_ready_o) w_cnt <= w_cnt + 1;
    if (r_valid_o && r_ready_i) begin
      r_cnt <= r_cnt + 1;
      r_cap <= r_o;
      r_cyc <= cycle;
    end
    if (b_valid_o && b_ready_i) begin
      b_cnt <= b_cnt + 1;
      b_cap <= b_o;
      b_cyc <= cycle;
    end
  end

  function automatic void add_entry(op_e op, logic [31:0] addr, logic [63:0] wdata,
                                    logic [7:0] wstrb, logic [3:0] id,
                                    logic [63:0] exp_rdata, soc_pkg::resp_e exp_resp);
    entry_t e;
    e.op        = op;
    e.addr      = addr;
    e.wdata     = wdata;
    e.wstrb     = wstrb;
    e.id        = id;
    e.exp_rdata = exp_rdata;
    e.exp_resp  = exp_resp;
    tbl.push_back(e);
  endfunction

  function automatic bit in_sram(logic [31:0] addr);
    return (addr >= soc_pkg::SRAM_BASE) &&
           (addr < soc_pkg::SRAM_BASE + 32'(SRAM_WORDS * 8));
  endfunction

  task automatic check_equal(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic read_word(input logic [31:0] addr, input logic [3:0] id, input int hold);
    int ar0;
    int r0;
    ar0 = ar_cnt;
    r0 = r_cnt;
    ar_i.araddr = addr;
    ar_i.arid = id;
    ar_valid_i = 1'b1;
    while (ar_cnt == ar0) @(negedge clk);
    ar_valid_i = 1'b0;
    while (!r_valid_o) @(negedge clk);
    repeat (hold) @(negedge clk);
    r_ready_i = 1'b1;
    while (r_cnt == r0) @(negedge clk);
    r_ready_i = 1'b0;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb, input logic [3:0] id, input int hold);
    int aw0;
    int w0;
    int b0;
    aw0 = aw_cnt;
    w0 = w_cnt;
    b0 = b_cnt;
    aw_i.awaddr = addr;
    aw_i.awid = id;
    aw_valid_i = 1'b1;
    w_i.wdata = data;
    w_i.wstrb = strb;
    w_valid_i = 1'b1;
    while (aw_valid_i || w_valid_i) begin
      @(negedge clk);
      if (aw_cnt != aw0) aw_valid_i = 1'b0;
      if (w_cnt != w0) w_valid_i = 1'b0;
    end
    while (!b_valid_o) @(negedge clk);
    repeat (hold) @(negedge clk);
    b_ready_i = 1'b1;
    while (b_cnt == b0) @(negedge clk);
    b_ready_i = 1'b0;
  endtask

  // 8N1 line decoder sampling mid-bit
  initial begin
    logic [7:0] rx;
    forever begin
      @(negedge uart_txd_o);
      #(BIT_NS / 2);
      assert (uart_txd_o === 1'b0) else begin
        $display("uart start bit did not stay low");
        errors++;
      end
      for (int i = 0; i < 8; i++) begin
        #(BIT_NS);
        rx[i] = uart_txd_o;
      end
      #(BIT_NS);
      assert (uart_txd_o === 1'b1) else begin
        $display("uart frame for byte %h has a low stop bit", rx);
        errors++;
      end
      rx_bytes.push_back(rx);
    end
  end

  initial begin
    wait (limit > 0);
    while (cycle < limit) @(negedge clk);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("test failed");
    $finish;
  end

  initial begin
    entry_t      e;
    int          hold_r;
    int          hold_w;
    int          err0;
    int          idx;
    int          ok_cnt;
    int          bad_cnt;
    logic [3:0]  wid;
    logic [63:0] exp_data;
    ok_cnt = 0;
    bad_cnt = 0;
    rst_n_i = 1'b0;
    ar_valid_i = 1'b0;
    ar_i = '0;
    aw_valid_i = 1'b0;
    aw_i = '0;
    w_valid_i = 1'b0;
    w_i = '0;
    r_ready_i = 1'b0;
    b_ready_i = 1'b0;

    add_entry(OP_WR, 32'h8000_0000, 64'h0123_4567_89ab_cdef, 8'hff, 4'h1, 64'h0, OK);
    add_entry(OP_RD, 32'h8000_0000, 64'h0, 8'h00, 4'h2, 64'h0, OK);
    // byte lane merge on one word
    add_entry(OP_WR, 32'h8000_0008, 64'h1111_2222_3333_4444, 8'hff, 4'h3, 64'h0, OK);
    add_entry(OP_WR, 32'h8000_0008, 64'haaaa_bbbb_cccc_dddd, 8'h0f, 4'h4, 64'h0, OK);
    add_entry(OP_WR, 32'h8000_0008, 64'h5555_6666_7777_8888, 8'h30, 4'h5, 64'h0, OK);
    add_entry(OP_RD, 32'h8000_0008, 64'h0, 8'h00, 4'h6, 64'h0, OK);
    // second byte queues behind the first frame
    add_entry(OP_WR, soc_pkg::SERIAL_ADDR, 64'hdead_beef_0000_0041, 8'hff, 4'h7, 64'h0, OK);
    add_entry(OP_WR, soc_pkg::SERIAL_ADDR, 64'h0000_0000_0000_00a5, 8'h01, 4'h8, 64'h0, OK);
    add_entry(OP_RD, 32'h2000_0000, 64'h0, 8'h00, 4'h9, 64'h0, DE);
    add_entry(OP_WR, 32'h2000_0000, 64'hffff_ffff_ffff_ffff, 8'hff, 4'ha, 64'h0, DE);
    add_entry(OP_WR, 32'h8000_2000, 64'hffff_ffff_ffff_ffff, 8'hff, 4'hb, 64'h0, DE);
    add_entry(OP_RD, 32'h7fff_fff8, 64'h0, 8'h00, 4'hc, 64'h0, DE);
    add_entry(OP_RD, 32'h8000_0000, 64'h0, 8'h00, 4'hd, 64'h0, OK);
    // ar and aw in the same cycle
    add_entry(OP_RDWR, 32'h8000_0008, 64'hfeed_face_cafe_f00d, 8'hff, 4'he, 64'h0, OK);
    add_entry(OP_RD, 32'h8000_0008, 64'h0, 8'h00, 4'h0, 64'h0, OK);
    add_entry(OP_WR, 32'h8000_1ff8, 64'h0f0f_0f0f_f0f0_f0f0, 8'hff, 4'h1, 64'h0, OK);
    add_entry(OP_RD, 32'h8000_1ff8, 64'h0, 8'h00, 4'h2, 64'h0, OK);
    limit = tbl.size() * 200 + 10 * CLKS_PER_BIT;

    repeat (5) @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);

    for (int i = 0; i < tbl.size(); i++) begin
      e = tbl[i];
      err0 = errors;
      hold_r = {$random(seed)} % 4;
      hold_w = {$random(seed)} % 4;
      idx = int'((e.addr - soc_pkg::SRAM_BASE) >> 3);
      exp_data = (in_sram(e.addr) && sb.exists(idx)) ? sb[idx] : e.exp_rdata;
      wid = (e.op == OP_WR) ? e.id : e.id + 4'd1;
      case (e.op)
        OP_RD: read_word(e.addr, e.id, hold_r);
        OP_WR: write_word(e.addr, e.wdata, e.wstrb, wid, hold_w);
        default: begin
          fork
            read_word(e.addr, e.id, hold_r);
            write_word(e.addr, e.wdata, e.wstrb, wid, hold_w);
          join
          assert (r_cyc < b_cyc) else begin
            $display("write response arrived before the read response");
            errors++;
          end
        end
      endcase
      if (e.op != OP_WR) begin
        check_equal("rdata", r_cap.rdata, exp_data);
        check_equal("rresp", 64'(r_cap.rresp), 64'(e.exp_resp));
        check_equal("rid", 64'(r_cap.rid), 64'(e.id));
        check_equal("rlast", 64'(r_cap.rlast), 64'd1);
      end
      if (e.op != OP_RD) begin
        check_equal("bresp", 64'(b_cap.bresp), 64'(e.exp_resp));
        check_equal("bid", 64'(b_cap.bid), 64'(wid));
        if (in_sram(e.addr)) begin
          for (int b = 0; b < 8; b++) begin
            if (e.wstrb[b]) sb[idx][b*8 +: 8] = e.wdata[b*8 +: 8];
          end
        end
        if (e.addr == soc_pkg::SERIAL_ADDR) exp_bytes.push_back(e.wdata[7:0]);
      end
      if (errors == err0) ok_cnt++;
      else bad_cnt++;
      $display("entry %0d %s addr %h id %h: %s", i, e.op.name(), e.addr, e.id,
               (errors == err0) ? "ok" : "bad");
    end

    err0 = errors;
    while (rx_bytes.size() < exp_bytes.size()) @(negedge clk);
    // error writes must not reach the serial line
    check_equal("uart count", 64'(rx_bytes.size()), 64'(exp_bytes.size()));
    foreach (exp_bytes[j]) begin
      check_equal("uart byte", 64'(rx_bytes[j]), 64'(exp_bytes[j]));
    end
    if (errors == err0) ok_cnt++;
    else bad_cnt++;
    $display("uart %0d bytes: %s", rx_bytes.size(), (errors == err0) ? "ok" : "bad");
    $display("summary: %0d ok, %0d bad, %0d errors", ok_cnt, bad_cnt, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: sources.f
common/soc_pkg.sv
mem_axi/sram_bank.sv
mem_axi/axi_mem_ctrl.sv
hdl/uart_tx.sv
hdl/soc_top.sv
sim/soc_properties.sv
sim/tb_soc.sv

// File: Makefile
TOP := tb_soc

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	verilator --lint-only -Wall --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir
